// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbRouterOutput
SEED_ARGS ?= +verilator+seed+27544
BUILD_DIR ?= obj_dir

.PHONY: sim clean

# The run exits with a failing status whenever the testbench stops on $fatal.
sim:
	$(VERILATOR) --binary --top-module $(TOP) -f list.f --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: grantTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module grantTimer (
  input  logic                     clk,
  input  logic                     rst,
  input  routerPkg::flitId_t       headId,
  input  logic [`LENGTH_WIDTH-1:0] headLength,
  input  logic                     run,
  output logic                     timesUp
);
  import routerPkg::*;

  logic [`LENGTH_WIDTH-1:0] budget;
  logic [`LENGTH_WIDTH-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      // Every header reaching the head of the FIFO sets a new budget.
      if (headId == HEADER)
        budget <= headLength;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // With the count starting at zero, a grant lasts at most budget+1 cycles.
  assign timesUp = (count == budget);

endmodule

`default_nettype wire

// File: inputPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module inputPort (
  input  logic            clk,
  input  logic            rst,
  input  logic            valid,
  input  routerPkg::flit_u flit,
  output logic            overflow,
  portLinkIf.source       link
);
  import routerPkg::*;

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  flit_u            mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             doWrite;
  logic             doPop;
  flit_u            head;

  assign full    = (count == CNT_W'(`FIFO_DEPTH));
  assign doPop   = link.pop && link.req;
  // A pop in the same cycle frees a slot, so a write into a full FIFO still lands.
  assign doWrite = valid && (!full || doPop);

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= flit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({doWrite, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      overflow <= valid && full && !doPop;
    end
  end

  assign head = mem[rdPtr];

  assign link.req        = (count != '0);
  assign link.headFlit   = head;
  // An empty FIFO shows no header, so a stale slot never reloads the timer.
  assign link.headId     = link.req ? head.body.flitId : BODY;
  assign link.headLength = head.header.length;

endmodule

`default_nettype wire

// File: list.f
+incdir+.
routerPkg.sv
portLinkIf.sv
inputPort.sv
grantTimer.sv
outputArbiter.sv
routerOutputStage.sv
tbRouterOutput.sv

// File: outputArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module outputArbiter (
  input  logic              clk,
  input  logic              rst,
  portLinkIf.sink           lLink,
  portLinkIf.sink           nLink,
  portLinkIf.sink           eLink,
  portLinkIf.sink           wLink,
  portLinkIf.sink           sLink,
  output routerPkg::grant_t grant,
  output logic              outValid,
  output routerPkg::flit_u  outFlit
);
  import routerPkg::*;

  localparam int PORT_IDX_W = $clog2(`NUM_PORTS);

  grant_t                   state;
  grant_t                   nextState;
  logic [`NUM_PORTS-1:0]    reqVec;
  logic [`NUM_PORTS-1:0]    timesUp;
  logic [`NUM_PORTS-1:0]    run;
  logic [`NUM_PORTS-1:0]    pop;
  flitId_t                  headIdVec [`NUM_PORTS];
  logic [`LENGTH_WIDTH-1:0] headLenVec [`NUM_PORTS];
  flit_u                    headVec [`NUM_PORTS];
  logic [PORT_IDX_W-1:0]    ownerIdx;
  logic                     granted;

  // Index 0 is L, then N, E, W and S, matching grant bits 1 to 5.
  assign reqVec = {sLink.req, wLink.req, eLink.req, nLink.req, lLink.req};

  assign headVec[0] = lLink.headFlit;
  assign headVec[1] = nLink.headFlit;
  assign headVec[2] = eLink.headFlit;
  assign headVec[3] = wLink.headFlit;
  assign headVec[4] = sLink.headFlit;

  assign headIdVec[0] = lLink.headId;
  assign headIdVec[1] = nLink.headId;
  assign headIdVec[2] = eLink.headId;
  assign headIdVec[3] = wLink.headId;
  assign headIdVec[4] = sLink.headId;

  assign headLenVec[0] = lLink.headLength;
  assign headLenVec[1] = nLink.headLength;
  assign headLenVec[2] = eLink.headLength;
  assign headLenVec[3] = wLink.headLength;
  assign headLenVec[4] = sLink.headLength;

  assign lLink.pop = pop[0];
  assign nLink.pop = pop[1];
  assign eLink.pop = pop[2];
  assign wLink.pop = pop[3];
  assign sLink.pop = pop[4];

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    grantTimer timer0 (
      .clk        (clk),
      .rst        (rst),
      .headId     (headIdVec[p]),
      .headLength (headLenVec[p]),
      .run        (run[p]),
      .timesUp    (timesUp[p])
    );
  end

  // Scans ports from start onwards, wrapping, and returns the first one requesting.
  function automatic grant_t firstRequester(input logic [`NUM_PORTS-1:0] reqs,
                                            input int start);
    grant_t pick;
    int     idx;
    pick = GRANT_IDLE;
    for (int i = `NUM_PORTS - 1; i >= 0; i--)
    begin
      idx = (start + i) % `NUM_PORTS;
      if (reqs[idx])
      begin
        pick = '0;
        pick[idx + 1] = 1'b1;
      end
    end
    return pick;
  endfunction

  always_comb
  begin
    granted  = 1'b1;
    ownerIdx = '0;
    case (state)
      GRANT_L: ownerIdx = PORT_IDX_W'(0);
      GRANT_N: ownerIdx = PORT_IDX_W'(1);
      GRANT_E: ownerIdx = PORT_IDX_W'(2);
      GRANT_W: ownerIdx = PORT_IDX_W'(3);
      GRANT_S: ownerIdx = PORT_IDX_W'(4);
      default: granted  = 1'b0;
    endcase
  end

  always_comb
  begin
    run = '0;
    if (!granted)
      nextState = firstRequester(reqVec, 0);
    else if (reqVec[ownerIdx] && !timesUp[ownerIdx])
    begin
      run[ownerIdx] = 1'b1;
      nextState     = state;
    end
    else
      // Rotation starts after the owner and ends with the owner itself.
      nextState = firstRequester(reqVec, int'(ownerIdx) + 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= GRANT_IDLE;
    else
      state <= nextState;
  end

  assign grant = state;
  assign pop   = state[`NUM_PORTS:1] & reqVec;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
      outFlit <= headVec[ownerIdx];
  end

endmodule

`default_nettype wire

// File: portLinkIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

interface portLinkIf;
  import routerPkg::*;

  logic                     req;
  flit_u                    headFlit;
  flitId_t                  headId;
  logic [`LENGTH_WIDTH-1:0] headLength;
  logic                     pop;

  modport source (
    output req,
    output headFlit,
    output headId,
    output headLength,
    input  pop
  );

  modport sink (
    input  req,
    input  headFlit,
    input  headId,
    input  headLength,
    output pop
  );

endinterface

`default_nettype wire

// File: routerOutputStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module routerOutputStage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   lValid,
  input  logic                   nValid,
  input  logic                   eValid,
  input  logic                   wValid,
  input  logic                   sValid,
  input  routerPkg::flit_u       lFlit,
  input  routerPkg::flit_u       nFlit,
  input  routerPkg::flit_u       eFlit,
  input  routerPkg::flit_u       wFlit,
  input  routerPkg::flit_u       sFlit,
  output logic                   outValid,
  output routerPkg::flit_u       outFlit,
  output routerPkg::grant_t      grant,
  output logic [`NUM_PORTS-1:0]  overflow
);

  portLinkIf lLink ();
  portLinkIf nLink ();
  portLinkIf eLink ();
  portLinkIf wLink ();
  portLinkIf sLink ();

  // Overflow bits follow the port order L, N, E, W, S from bit 0.
  inputPort lPort (.clk(clk), .rst(rst), .valid(lValid), .flit(lFlit),
                   .overflow(overflow[0]), .link(lLink.source));
  inputPort nPort (.clk(clk), .rst(rst), .valid(nValid), .flit(nFlit),
                   .overflow(overflow[1]), .link(nLink.source));
  inputPort ePort (.clk(clk), .rst(rst), .valid(eValid), .flit(eFlit),
                   .overflow(overflow[2]), .link(eLink.source));
  inputPort wPort (.clk(clk), .rst(rst), .valid(wValid), .flit(wFlit),
                   .overflow(overflow[3]), .link(wLink.source));
  inputPort sPort (.clk(clk), .rst(rst), .valid(sValid), .flit(sFlit),
                   .overflow(overflow[4]), .link(sLink.source));

  outputArbiter arbiter0 (
    .clk      (clk),
    .rst      (rst),
    .lLink    (lLink.sink),
    .nLink    (nLink.sink),
    .eLink    (eLink.sink),
    .wLink    (wLink.sink),
    .sLink    (sLink.sink),
    .grant    (grant),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

endmodule

`default_nettype wire

// File: routerPkg.sv
`default_nettype none

`include "router_defs.svh"

package routerPkg;

  typedef enum logic [2:0] {
    HEADER = 3'b001,
    BODY   = 3'b010,
    TAIL   = 3'b100
  } flitId_t;

  typedef struct packed {
    flitId_t                                    flitId;
    logic [4:0]                                 dest;
    logic [`LENGTH_WIDTH-1:0]                   length;
    logic [`FLIT_WIDTH-8-`LENGTH_WIDTH-1:0]     spare;
  } headerView_t;

  typedef struct packed {
    flitId_t                 flitId;
    logic [`FLIT_WIDTH-4:0]  payload;
  } bodyView_t;

  // The same word seen either as a header or as a body/tail flit.
  typedef union packed {
    headerView_t header;
    bodyView_t   body;
  } flit_u;

  // Bit 0 is idle, bits 1 to 5 grant L, N, E, W, S.
  typedef logic [`NUM_PORTS:0] grant_t;

  localparam grant_t GRANT_IDLE = 6'b000001;
  localparam grant_t GRANT_L    = 6'b000010;
  localparam grant_t GRANT_N    = 6'b000100;
  localparam grant_t GRANT_E    = 6'b001000;
  localparam grant_t GRANT_W    = 6'b010000;
  localparam grant_t GRANT_S    = 6'b100000;

endpackage

`default_nettype wire

// File: router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// Number of input ports. The one-hot grant encoding assumes five.
`define NUM_PORTS 5

// Width of one flit on the links and in the FIFOs.
`define FLIT_WIDTH 32

// Width of the header length field and of the grant timers.
`define LENGTH_WIDTH 12

// Entries per input FIFO, a power of two.
`define FIFO_DEPTH 4

`endif

// File: tbRouterOutput.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module tbRouterOutput;
  import routerPkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  logic                  clk;
  logic                  rst;
  logic [`NUM_PORTS-1:0] validIn;
  flit_u                 flitIn [`NUM_PORTS];
  logic                  outValid;
  flit_u                 outFlit;
  grant_t                grant;
  logic [`NUM_PORTS-1:0] overflow;

  // Flits that each port still owes the output link, oldest first.
  flit_u  expQ [`NUM_PORTS][$];
  grant_t grantTrace[$];
  grant_t lastGrant;
  int     overflowCount [`NUM_PORTS];

  routerOutputStage dut0 (
    .clk(clk), .rst(rst),
    .lValid(validIn[0]), .lFlit(flitIn[0]),
    .nValid(validIn[1]), .nFlit(flitIn[1]),
    .eValid(validIn[2]), .eFlit(flitIn[2]),
    .wValid(validIn[3]), .wFlit(flitIn[3]),
    .sValid(validIn[4]), .sFlit(flitIn[4]),
    .outValid(outValid), .outFlit(outFlit),
    .grant(grant), .overflow(overflow)
  );

  always #50 clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic checkFlit(input string name, input flit_u got, input flit_u exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abortRun("Flit mismatch.");
    end
  endtask

  task automatic checkGrant(input string name, input grant_t got, input grant_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abortRun("Grant mismatch.");
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abortRun("Flag mismatch.");
    end
  endtask

  function automatic grant_t grantFor(input int port);
    return grant_t'(1) << (port + 1);
  endfunction

  function automatic int portOf(input grant_t g);
    int found;
    found = -1;
    for (int p = 0; p < `NUM_PORTS; p++)
      if (g == grantFor(p))
        found = p;
    return found;
  endfunction

  function automatic flit_u makeHeader(input logic [`LENGTH_WIDTH-1:0] len);
    flit_u f;
    f = $urandom;
    f.header.flitId = HEADER;
    f.header.length = len;
    return f;
  endfunction

  function automatic flit_u makeBody();
    flit_u f;
    f = $urandom;
    f.body.flitId = BODY;
    return f;
  endfunction

  // Moves to the next falling edge, checks the outputs there and clears the strobes.
  task automatic nextCycle();
    int    port;
    flit_u expFlit;
    @(negedge clk);
    if ($countones(grant) != 1)
      abortRun("The grant state is not one-hot.");
    if (outValid)
    begin
      // The flit was popped in the cycle before, under the grant seen then.
      port = portOf(lastGrant);
      if (port < 0)
        abortRun("A flit left the router without a granted port one cycle before.");
      else if (expQ[port].size() == 0)
        abortRun($sformatf("Port %0d sent a flit that it never received.", port));
      else
      begin
        expFlit = expQ[port].pop_front();
        checkFlit("outFlit", outFlit, expFlit);
      end
    end
    for (int p = 0; p < `NUM_PORTS; p++)
      if (overflow[p])
        overflowCount[p]++;
    grantTrace.push_back(grant);
    lastGrant = grant;
    validIn = '0;
  endtask

  task automatic pushFlit(input int port, input flit_u f, input logic expectOut);
    validIn[port] = 1'b1;
    flitIn[port]  = f;
    if (expectOut)
      expQ[port].push_back(f);
  endtask

  task automatic waitDrained();
    int n;
    int pending;
    n = 0;
    pending = 1;
    while (pending != 0 || grant != GRANT_IDLE || outValid)
    begin
      if (n == TIMEOUT_CYCLES)
        abortRun("Timed out waiting for the router to drain and go idle.");
      else
      begin
        nextCycle();
        n++;
        pending = 0;
        for (int p = 0; p < `NUM_PORTS; p++)
          pending += expQ[p].size();
      end
    end
  endtask

  task automatic testResetAndPacket();
    checkGrant("grant", grant, GRANT_IDLE);
    checkBit("outValid", outValid, 1'b0);
    for (int p = 0; p < `NUM_PORTS; p++)
      checkBit($sformatf("overflow[%0d]", p), overflow[p], 1'b0);
    nextCycle();
    pushFlit(0, makeHeader(`LENGTH_WIDTH'(4)), 1'b1);
    nextCycle();
    pushFlit(0, makeBody(), 1'b1);
    nextCycle();
    pushFlit(0, makeBody(), 1'b1);
    nextCycle();
    waitDrained();
  endtask

  task automatic testFixedPriority();
    int first;
    grantTrace.delete();
    nextCycle();
    for (int p = 0; p < `NUM_PORTS; p++)
      pushFlit(p, makeHeader(`LENGTH_WIDTH'(0)), 1'b1);
    nextCycle();
    waitDrained();
    first = 0;
    while (first < grantTrace.size() && grantTrace[first] == GRANT_IDLE)
      first++;
    if (first == grantTrace.size())
      abortRun("No port was granted after all five ports were loaded.");
    else
      checkGrant("first grant", grantTrace[first], GRANT_L);
  endtask

  task automatic testRotation();
    grant_t owners[$];
    int     expPort;
    grantTrace.delete();
    for (int c = 0; c < 3; c++)
    begin
      nextCycle();
      for (int p = 0; p < `NUM_PORTS; p++)
        pushFlit(p, (c == 0) ? makeHeader(`LENGTH_WIDTH'(1)) : makeBody(), 1'b1);
    end
    nextCycle();
    waitDrained();
    for (int i = 0; i < grantTrace.size(); i++)
      if (grantTrace[i] != GRANT_IDLE && (i == 0 || grantTrace[i] != grantTrace[i - 1]))
        owners.push_back(grantTrace[i]);
    if (owners.size() < 6)
      abortRun($sformatf("Only %0d grant owners seen, six expected.", owners.size()));
    // Every port keeps requesting, so each rotation lands on the port after the owner.
    expPort = 0;
    for (int i = 0; i < 6; i++)
    begin
      checkGrant($sformatf("owner[%0d]", i), owners[i], grantFor(expPort));
      expPort = (expPort + 1) % `NUM_PORTS;
    end
  endtask

  task automatic testTimerExpiry();
    int first;
    int held;
    grantTrace.delete();
    nextCycle();
    pushFlit(1, makeHeader(`LENGTH_WIDTH'(2)), 1'b1);
    pushFlit(2, makeHeader(`LENGTH_WIDTH'(0)), 1'b1);
    nextCycle();
    pushFlit(1, makeBody(), 1'b1);
    pushFlit(2, makeBody(), 1'b1);
    for (int c = 0; c < 2; c++)
    begin
      nextCycle();
      pushFlit(1, makeBody(), 1'b1);
    end
    nextCycle();
    waitDrained();
    first = 0;
    while (first < grantTrace.size() && grantTrace[first] != GRANT_N)
      first++;
    held = 0;
    while (first + held < grantTrace.size() && grantTrace[first + held] == GRANT_N)
      held++;
    // N still has flits, so only the length 2 budget ends its grant after 3 cycles.
    if (held != 3)
      abortRun($sformatf("Port N held the grant for %0d cycles instead of 3.", held));
    else if (first + held >= grantTrace.size())
      abortRun("The grant trace ends while port N still owns the link.");
    else
      checkGrant("grant after N", grantTrace[first + held], GRANT_E);
  endtask

  // Overflow pulses are counted over the whole run, so earlier tests must leave none.
  task automatic testOverflow();
    // W keeps the grant with a long budget while S is written one flit past full.
    for (int c = 0; c < 10; c++)
    begin
      nextCycle();
      pushFlit(3, (c == 0) ? makeHeader(`LENGTH_WIDTH'(20)) : makeBody(), 1'b1);
      if (c >= 2 && c < 3 + `FIFO_DEPTH)
        pushFlit(4, (c == 2) ? makeHeader(`LENGTH_WIDTH'(10)) : makeBody(),
                 c < 2 + `FIFO_DEPTH);
    end
    nextCycle();
    waitDrained();
    for (int p = 0; p < `NUM_PORTS; p++)
      if (overflowCount[p] != ((p == 4) ? 1 : 0))
        abortRun($sformatf("Port %0d raised overflow %0d times.", p, overflowCount[p]));
  endtask

  initial
  begin
    void'($urandom(32'h6b98));
    clk       = 1'b0;
    rst       = 1'b1;
    validIn   = '0;
    lastGrant = GRANT_IDLE;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      flitIn[p]        = '0;
      overflowCount[p] = 0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;
    testResetAndPacket();
    testFixedPriority();
    testRotation();
    testTimerExpiry();
    testOverflow();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
